/* logic/rv_decode_pkg.sv */
package rv_decode_pkg;

    // ------------------------------------------------------------------------
    // Widths and value types
    // ------------------------------------------------------------------------
    typedef logic [31:0] addr_t;      // Instruction address
    typedef logic [31:0] inst_t;      // Raw instruction word
    typedef logic [31:0] data_t;      // Immediate or data value
    typedef logic [4:0]  reg_idx_t;   // Architectural register index
    typedef logic [2:0]  uop_t;       // Functional unit micro-op

    // RV32IM major opcodes
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_ari_itype = 7'b0010011;
    localparam logic [6:0] opc_ari_rtype = 7'b0110011;

    localparam logic [6:0] fnc7_muldiv = 7'b0000001;   // M extension marker
    localparam uop_t       fnc_add_sub = 3'b000;       // Default micro-op

    // Dispatch queue sizing
    localparam int queue_depth    = 4;
    localparam int queue_ptr_bits = $clog2(queue_depth);

    typedef logic [queue_ptr_bits-1:0] qptr_t;
    typedef logic [queue_ptr_bits:0]   qcnt_t;   // One extra bit to hold a full count

    // ------------------------------------------------------------------------
    // Stream payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        addr_t pc0;
        inst_t inst0;
        addr_t pc1;
        inst_t inst1;
    } fetch_pair_t;

    typedef struct packed {
        addr_t    pc;
        inst_t    inst;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
        logic     val;
        // Class flags
        logic     has_rd;
        logic     is_muldiv;
        logic     is_branch;
        logic     is_jump;
        logic     is_load;
        logic     is_store;
        logic     a_sel;      // 0 rs1, 1 PC
        logic     b_sel;      // 0 rs2, 1 immediate
        uop_t     uop;
        uop_t     uop_br;
    } decoded_inst_t;

    typedef struct packed {
        decoded_inst_t lane0;
        decoded_inst_t lane1;
    } decoded_pair_t;

endpackage

/* logic/fetch_skid.sv */
`timescale 1ns/1ps

module fetch_skid (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    // From fetch
    input  logic                      in_valid,
    output logic                      in_ready,
    input  rv_decode_pkg::fetch_pair_t in_pair,
    // Toward decode
    output logic                      skid_valid,
    input  logic                      skid_ready,
    output rv_decode_pkg::fetch_pair_t skid_pair
);

    logic                       main_valid;
    logic                       spill_valid;
    rv_decode_pkg::fetch_pair_t main_pair;
    rv_decode_pkg::fetch_pair_t spill_pair;
    logic                       in_fire;
    logic                       main_free;

    // Ready comes straight from state, never from downstream ready
    assign in_ready   = !spill_valid;
    assign in_fire    = in_valid && in_ready;
    assign main_free  = !main_valid || skid_ready;   // Main slot empties this cycle

    assign skid_valid = main_valid;
    assign skid_pair  = main_pair;

    // ------------------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (flush) begin
            main_valid  <= 1'b0;   // Same-edge input is dropped too
            spill_valid <= 1'b0;
        end else if (main_free) begin
            // Spill drains first so order holds
            main_valid  <= spill_valid || in_fire;
            spill_valid <= 1'b0;
        end else if (in_fire) begin
            spill_valid <= 1'b1;   // Main stalled, park the new pair
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (main_free) begin
            main_pair <= spill_valid ? spill_pair : in_pair;
        end else if (in_fire) begin
            spill_pair <= in_pair;
        end
    end

endmodule

/* logic/dual_decode.sv */
`timescale 1ns/1ps

module dual_decode (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    // From skid buffer
    input  logic                         skid_valid,
    output logic                         skid_ready,
    input  rv_decode_pkg::fetch_pair_t    skid_pair,
    // Toward dispatch queue
    output logic                         dec_valid,
    input  logic                         dec_ready,
    output rv_decode_pkg::decoded_pair_t  dec_pair
);

    // ------------------------------------------------------------------------
    // Immediate generation
    // ------------------------------------------------------------------------
    function automatic rv_decode_pkg::data_t gen_imm(input rv_decode_pkg::inst_t inst);
        case (inst[6:0])
            rv_decode_pkg::opc_ari_itype,
            rv_decode_pkg::opc_load,
            rv_decode_pkg::opc_jalr:
                return {{20{inst[31]}}, inst[31:20]};                              // I
            rv_decode_pkg::opc_store:
                return {{20{inst[31]}}, inst[31:25], inst[11:7]};                  // S
            rv_decode_pkg::opc_branch:
                return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};   // B
            rv_decode_pkg::opc_lui,
            rv_decode_pkg::opc_auipc:
                return {inst[31:12], 12'b0};                                       // U
            rv_decode_pkg::opc_jal:
                return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}; // J
            default:
                return '0;
        endcase
    endfunction

    // Full record for one lane, val left clear
    function automatic rv_decode_pkg::decoded_inst_t decode_inst(
        input rv_decode_pkg::addr_t pc,
        input rv_decode_pkg::inst_t inst
    );
        rv_decode_pkg::decoded_inst_t d;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;

        opcode = inst[6:0];
        funct3 = inst[14:12];
        funct7 = inst[31:25];

        d      = '0;
        d.pc   = pc;
        d.inst = inst;
        d.rd   = inst[11:7];
        d.rs1  = inst[19:15];
        d.rs2  = inst[24:20];
        d.imm  = gen_imm(inst);
        d.uop  = rv_decode_pkg::fnc_add_sub;
        d.b_sel = 1'b1;   // Immediate unless R-type

        case (opcode)
            rv_decode_pkg::opc_lui: d.has_rd = 1'b1;
            rv_decode_pkg::opc_auipc: begin
                d.has_rd = 1'b1;
                d.a_sel  = 1'b1;
            end
            rv_decode_pkg::opc_jal: begin
                d.has_rd  = 1'b1;
                d.is_jump = 1'b1;
                d.a_sel   = 1'b1;
            end
            rv_decode_pkg::opc_jalr: begin
                d.has_rd  = 1'b1;
                d.is_jump = 1'b1;
            end
            rv_decode_pkg::opc_branch: begin
                d.is_branch = 1'b1;
                d.a_sel     = 1'b1;   // Target is PC relative
                d.uop_br    = funct3;
            end
            rv_decode_pkg::opc_load: begin
                d.has_rd  = 1'b1;
                d.is_load = 1'b1;
                d.uop     = funct3;   // Access size
            end
            rv_decode_pkg::opc_store: begin
                d.is_store = 1'b1;
                d.uop      = funct3;
            end
            rv_decode_pkg::opc_ari_itype: begin
                d.has_rd = 1'b1;
                d.uop    = funct3;
            end
            rv_decode_pkg::opc_ari_rtype: begin
                d.has_rd    = 1'b1;
                d.is_muldiv = (funct7 == rv_decode_pkg::fnc7_muldiv);
                d.b_sel     = 1'b0;
                d.uop       = funct3;
            end
            default: ;   // Unknown opcodes keep the default record
        endcase
        return d;
    endfunction

    // ------------------------------------------------------------------------
    // Pipeline register
    // ------------------------------------------------------------------------
    rv_decode_pkg::decoded_pair_t dec_next;
    rv_decode_pkg::decoded_pair_t dec_q;

    always_comb begin
        dec_next = '0;   // Bubble when nothing arrives
        if (skid_valid) begin
            dec_next.lane0     = decode_inst(skid_pair.pc0, skid_pair.inst0);
            dec_next.lane1     = decode_inst(skid_pair.pc1, skid_pair.inst1);
            dec_next.lane0.val = 1'b1;
            dec_next.lane1.val = 1'b1;
        end
    end

    assign skid_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_q <= '0;
        end else if (flush) begin
            dec_q <= '0;
        end else if (skid_ready) begin
            dec_q <= dec_next;
        end
    end

    assign dec_valid = dec_q.lane0.val;   // Both lanes always travel together
    assign dec_pair  = dec_q;

endmodule

/* logic/dispatch_queue.sv */
`timescale 1ns/1ps

module dispatch_queue (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    // From decode
    input  logic                         dec_valid,
    output logic                         dec_ready,
    input  rv_decode_pkg::decoded_pair_t  dec_pair,
    // Toward dispatch
    output logic                         out_valid,
    input  logic                         out_ready,
    output rv_decode_pkg::decoded_pair_t  out_pair
);

    rv_decode_pkg::decoded_pair_t mem [rv_decode_pkg::queue_depth];

    rv_decode_pkg::qptr_t wr_ptr;
    rv_decode_pkg::qptr_t rd_ptr;
    rv_decode_pkg::qcnt_t count;
    logic                 wr_en;
    logic                 rd_en;

    // Status from the count register only
    assign dec_ready = count < rv_decode_pkg::qcnt_t'(rv_decode_pkg::queue_depth);
    assign out_valid = count != '0;
    assign out_pair  = mem[rd_ptr];

    assign wr_en = dec_valid && dec_ready;
    assign rd_en = out_valid && out_ready;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + rv_decode_pkg::qptr_t'(1);   // Wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + rv_decode_pkg::qptr_t'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + rv_decode_pkg::qcnt_t'(1);
                2'b01:   count <= count - rv_decode_pkg::qcnt_t'(1);
                default: count <= count;   // Idle or write plus read
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= dec_pair;
        end
    end

endmodule

/* logic/decode_top.sv */
`timescale 1ns/1ps

module decode_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    // Fetch side
    input  logic                         in_valid,
    output logic                         in_ready,
    input  rv_decode_pkg::fetch_pair_t    in_pair,
    // Dispatch side
    output logic                         out_valid,
    input  logic                         out_ready,
    output rv_decode_pkg::decoded_pair_t  out_pair
);

    // ------------------------------------------------------------------------
    // Inter-stage streams
    // ------------------------------------------------------------------------
    logic                         skid_valid;
    logic                         skid_ready;
    rv_decode_pkg::fetch_pair_t   skid_pair;
    logic                         dec_valid;
    logic                         dec_ready;
    rv_decode_pkg::decoded_pair_t dec_pair;

    fetch_skid skid_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pair    (in_pair),
        .skid_valid (skid_valid),
        .skid_ready (skid_ready),
        .skid_pair  (skid_pair)
    );

    dual_decode decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .skid_valid (skid_valid),
        .skid_ready (skid_ready),
        .skid_pair  (skid_pair),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec_pair   (dec_pair)
    );

    // Output FIFO toward dispatch
    dispatch_queue queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pair  (dec_pair),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pair  (out_pair)
    );

endmodule

/* testbench/decode_chk.sv */
`timescale 1ns/1ps

module decode_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         flush,
    input logic                         skid_valid,
    input logic                         skid_ready,
    input rv_decode_pkg::fetch_pair_t   skid_pair,
    input logic                         dec_valid,
    input logic                         dec_ready,
    input rv_decode_pkg::decoded_pair_t dec_pair,
    input logic                         out_valid,
    input logic                         out_ready,
    input rv_decode_pkg::decoded_pair_t out_pair
);

    int fail_count;   // Failed assertions so far

    // ------------------------------------------------------------------------
    // Stalled streams keep valid and data until the transfer
    // ------------------------------------------------------------------------
    skid_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        skid_valid && !skid_ready && !flush |=> skid_valid && $stable(skid_pair))
        else begin
            fail_count++;
            $error("skid stream dropped valid or changed data while stalled");
        end

    dec_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready && !flush |=> dec_valid && $stable(dec_pair))
        else begin
            fail_count++;
            $error("decode stream dropped valid or changed data while stalled");
        end

    out_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_pair))
        else begin
            fail_count++;
            $error("output stream dropped valid or changed data while stalled");
        end

    // Queue is empty right after a flush
    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after a flush");
        end

endmodule

bind decode_top decode_chk chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .skid_valid (skid_valid),
    .skid_ready (skid_ready),
    .skid_pair  (skid_pair),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec_pair   (dec_pair),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_pair   (out_pair)
);

/* testbench/decode_scoreboard.sv */
`timescale 1ns/1ps

module decode_scoreboard (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         in_valid,
    input  logic                         in_ready,
    input  rv_decode_pkg::fetch_pair_t   in_pair,
    input  logic                         out_valid,
    input  logic                         out_ready,
    input  rv_decode_pkg::decoded_pair_t out_pair,
    input  logic                         expect_idle,
    input  logic                         check_latency,
    input  logic                         test_done,
    output int                           pending,
    output int                           mismatch_count,
    output int                           other_count
);

    rv_decode_pkg::decoded_pair_t exp_q[$];
    int                           accept_q[$];   // Cycle of each input transfer
    int                           cycle;
    logic                         end_checked;

    // ------------------------------------------------------------------------
    // Reference decode, straight from the RV32IM encoding tables
    // ------------------------------------------------------------------------
    function automatic rv_decode_pkg::data_t ref_imm(input rv_decode_pkg::inst_t inst);
        logic signed [31:0] s;
        s = '0;
        case (inst[6:0])
            rv_decode_pkg::opc_ari_itype,
            rv_decode_pkg::opc_load,
            rv_decode_pkg::opc_jalr: s = $signed(inst) >>> 20;
            rv_decode_pkg::opc_store: begin
                s = {inst[31:25], inst[11:7], 20'b0};
                s = s >>> 20;
            end
            rv_decode_pkg::opc_branch: begin
                s = {inst[31], inst[7], inst[30:25], inst[11:8], 20'b0};
                s = s >>> 19;   // Lands at bit 1, bit 0 stays clear
            end
            rv_decode_pkg::opc_lui,
            rv_decode_pkg::opc_auipc: s = {inst[31:12], 12'b0};
            rv_decode_pkg::opc_jal: begin
                s = {inst[31], inst[19:12], inst[20], inst[30:21], 12'b0};
                s = s >>> 11;
            end
            default: s = '0;
        endcase
        return s;
    endfunction

    function automatic rv_decode_pkg::decoded_inst_t ref_decode(
        input rv_decode_pkg::addr_t pc,
        input rv_decode_pkg::inst_t inst
    );
        rv_decode_pkg::decoded_inst_t e;
        logic [6:0]                   op;
        logic                         rtype;
        logic                         itype;

        op          = inst[6:0];
        rtype       = (op == rv_decode_pkg::opc_ari_rtype);
        itype       = (op == rv_decode_pkg::opc_ari_itype);
        e           = '0;
        e.pc        = pc;
        e.inst      = inst;
        e.rd        = inst[11:7];
        e.rs1       = inst[19:15];
        e.rs2       = inst[24:20];
        e.imm       = ref_imm(inst);
        e.val       = 1'b1;
        e.is_branch = (op == rv_decode_pkg::opc_branch);
        e.is_jump   = (op == rv_decode_pkg::opc_jal) || (op == rv_decode_pkg::opc_jalr);
        e.is_load   = (op == rv_decode_pkg::opc_load);
        e.is_store  = (op == rv_decode_pkg::opc_store);
        e.has_rd    = e.is_jump || e.is_load || rtype || itype
                   || (op == rv_decode_pkg::opc_lui) || (op == rv_decode_pkg::opc_auipc);
        e.is_muldiv = rtype && (inst[31:25] == rv_decode_pkg::fnc7_muldiv);
        e.a_sel     = e.is_branch || (op == rv_decode_pkg::opc_jal)
                   || (op == rv_decode_pkg::opc_auipc);
        e.b_sel     = !rtype;   // Unknown opcodes also pick the immediate
        e.uop       = (rtype || itype || e.is_load || e.is_store) ? inst[14:12]
                                                                   : rv_decode_pkg::fnc_add_sub;
        e.uop_br    = e.is_branch ? inst[14:12] : 3'b000;
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // Comparison
    // ------------------------------------------------------------------------
    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_lane(input string lane, input rv_decode_pkg::decoded_inst_t got,
                                input rv_decode_pkg::decoded_inst_t exp);
        check_field({lane, ".pc"}, got.pc, exp.pc);
        check_field({lane, ".inst"}, got.inst, exp.inst);
        check_field({lane, ".rd"}, 32'(got.rd), 32'(exp.rd));
        check_field({lane, ".rs1"}, 32'(got.rs1), 32'(exp.rs1));
        check_field({lane, ".rs2"}, 32'(got.rs2), 32'(exp.rs2));
        check_field({lane, ".imm"}, got.imm, exp.imm);
        check_field({lane, ".val"}, 32'(got.val), 32'(exp.val));
        check_field({lane, ".has_rd"}, 32'(got.has_rd), 32'(exp.has_rd));
        check_field({lane, ".is_muldiv"}, 32'(got.is_muldiv), 32'(exp.is_muldiv));
        check_field({lane, ".is_branch"}, 32'(got.is_branch), 32'(exp.is_branch));
        check_field({lane, ".is_jump"}, 32'(got.is_jump), 32'(exp.is_jump));
        check_field({lane, ".is_load"}, 32'(got.is_load), 32'(exp.is_load));
        check_field({lane, ".is_store"}, 32'(got.is_store), 32'(exp.is_store));
        check_field({lane, ".a_sel"}, 32'(got.a_sel), 32'(exp.a_sel));
        check_field({lane, ".b_sel"}, 32'(got.b_sel), 32'(exp.b_sel));
        check_field({lane, ".uop"}, 32'(got.uop), 32'(exp.uop));
        check_field({lane, ".uop_br"}, 32'(got.uop_br), 32'(exp.uop_br));
    endtask

    task automatic check_output();
        rv_decode_pkg::decoded_pair_t exp;
        int                           acc;
        if (exp_q.size() == 0) begin
            other_count++;
            $display("Output transfer arrived while no pair was expected");
        end else begin
            exp = exp_q.pop_front();
            acc = accept_q.pop_front();
            compare_lane("out_pair.lane0", out_pair.lane0, exp.lane0);
            compare_lane("out_pair.lane1", out_pair.lane1, exp.lane1);
            if (check_latency && (cycle - acc != 3)) begin
                other_count++;
                $display("Pair accepted in cycle %0d came out after %0d cycles, not 3",
                         acc, cycle - acc);
            end
        end
    endtask

    // Mid-cycle sample, values hold through the next rising edge
    always @(negedge clk) begin
        rv_decode_pkg::decoded_pair_t e;
        if (!rst_n) begin
            exp_q.delete();
            accept_q.delete();
            cycle       = 0;
            end_checked = 1'b0;
        end else begin
            cycle++;
            if (expect_idle && (out_valid || !in_ready)) begin
                other_count++;
                $display("Idle pipeline shows out_valid %0b and in_ready %0b in cycle %0d",
                         out_valid, in_ready, cycle);
            end
            if (flush) begin
                exp_q.delete();   // Everything in flight is dropped
                accept_q.delete();
            end else begin
                if (out_valid && out_ready) begin
                    check_output();
                end
                if (in_valid && in_ready) begin
                    e.lane0 = ref_decode(in_pair.pc0, in_pair.inst0);
                    e.lane1 = ref_decode(in_pair.pc1, in_pair.inst1);
                    exp_q.push_back(e);
                    accept_q.push_back(cycle);
                end
            end
            if (test_done && !end_checked) begin
                end_checked = 1'b1;
                if (exp_q.size() != 0) begin
                    other_count++;
                    $display("%0d accepted pairs never came out", exp_q.size());
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

/* testbench/tb_decode_top.sv */
`timescale 1ns/1ps

module tb_decode_top;

    localparam int num_kinds   = 11;   // Nine opcode classes, mul/div, invalid
    localparam int num_random  = 240;
    localparam int num_flushes = 3;
    localparam int num_pairs   = num_kinds + num_random + num_flushes;
    localparam int cycle_limit = 4 * num_pairs + 200;

    localparam logic [6:0] bad_opcodes [4] = '{7'b0001111, 7'b1110011, 7'b0000000, 7'b1111111};

    logic                         clk;
    logic                         rst_n;
    logic                         flush;
    logic                         in_valid;
    logic                         in_ready;
    rv_decode_pkg::fetch_pair_t   in_pair;
    logic                         out_valid;
    logic                         out_ready;
    rv_decode_pkg::decoded_pair_t out_pair;
    logic                         expect_idle;
    logic                         check_latency;
    logic                         test_done;
    logic                         ready_random;
    int                           pending;
    int                           mismatch_count;
    int                           other_count;
    int                           cycle_count;
    int                           total_errors;

    decode_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pair   (in_pair),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pair  (out_pair)
    );

    decode_scoreboard sb_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_pair        (in_pair),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_pair       (out_pair),
        .expect_idle    (expect_idle),
        .check_latency  (check_latency),
        .test_done      (test_done),
        .pending        (pending),
        .mismatch_count (mismatch_count),
        .other_count    (other_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the pipeline never drained", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic step();
        @(posedge clk);
        #2;
        if (ready_random) begin
            out_ready = ($urandom_range(1, 0) != 0);   // Stall about half the cycles
        end
    endtask

    function automatic rv_decode_pkg::inst_t make_inst(input int kind);
        rv_decode_pkg::inst_t inst;
        inst = $urandom();
        if (inst[27:26] == 2'b00) begin
            inst[31:25] = rv_decode_pkg::fnc7_muldiv;   // Marker on non R-type too
        end
        case (kind)
            0: inst[6:0] = rv_decode_pkg::opc_lui;
            1: inst[6:0] = rv_decode_pkg::opc_auipc;
            2: inst[6:0] = rv_decode_pkg::opc_jal;
            3: inst[6:0] = rv_decode_pkg::opc_jalr;
            4: inst[6:0] = rv_decode_pkg::opc_branch;
            5: inst[6:0] = rv_decode_pkg::opc_load;
            6: inst[6:0] = rv_decode_pkg::opc_store;
            7: inst[6:0] = rv_decode_pkg::opc_ari_itype;
            8: begin
                inst[6:0] = rv_decode_pkg::opc_ari_rtype;
                if (inst[31:25] == rv_decode_pkg::fnc7_muldiv) begin
                    inst[31:25] = 7'b0100000;   // Plain sub/sra encoding
                end
            end
            9: begin
                inst[6:0]   = rv_decode_pkg::opc_ari_rtype;
                inst[31:25] = rv_decode_pkg::fnc7_muldiv;
            end
            default: inst[6:0] = bad_opcodes[inst[13:12]];
        endcase
        return inst;
    endfunction

    function automatic rv_decode_pkg::fetch_pair_t make_pair(input int kind0, input int kind1);
        rv_decode_pkg::fetch_pair_t p;
        p.pc0   = $urandom() & 32'hffff_fffc;
        p.pc1   = p.pc0 + 32'd4;
        p.inst0 = make_inst(kind0);
        p.inst1 = make_inst(kind1);
        return p;
    endfunction

    // Hold valid until a rising edge sees in_ready
    task automatic send_pair(input rv_decode_pkg::fetch_pair_t p);
        logic accepted;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_pair  = p;
        while (!accepted) begin
            accepted = in_ready;
            step();
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending != 0) begin
            step();
        end
    endtask

    task automatic inject_flush();
        flush    = 1'b1;
        in_valid = 1'b1;   // Offered on the flush edge, so dropped
        in_pair  = make_pair($urandom_range(10, 0), $urandom_range(10, 0));
        step();
        flush    = 1'b0;
        in_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h317c));
        rst_n         = 1'b0;
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_pair       = '0;
        out_ready     = 1'b1;
        expect_idle   = 1'b1;
        check_latency = 1'b0;
        test_done     = 1'b0;
        ready_random  = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (8) step();
        expect_idle = 1'b0;

        // One pair in flight per class, fixed latency
        check_latency = 1'b1;
        for (int k = 0; k < num_kinds; k++) begin
            send_pair(make_pair(k, (k + 5) % num_kinds));
            wait_drain();
        end
        check_latency = 1'b0;

        // Input outpaces the output here, so back-pressure reaches the skid buffer
        ready_random = 1'b1;
        for (int i = 0; i < num_random; i++) begin
            if (i % 80 == 40) begin
                inject_flush();
            end
            repeat ($urandom_range(1, 0)) step();
            send_pair(make_pair($urandom_range(10, 0), $urandom_range(10, 0)));
        end

        ready_random = 1'b0;
        out_ready    = 1'b1;
        wait_drain();
        expect_idle = 1'b1;
        repeat (4) step();
        test_done = 1'b1;
        repeat (2) step();

        total_errors = mismatch_count + other_count + dut_i.chk_i.fail_count;
        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_count, other_count, dut_i.chk_i.fail_count);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* project.f */
logic/rv_decode_pkg.sv
logic/fetch_skid.sv
logic/dual_decode.sv
logic/dispatch_queue.sv
logic/decode_top.sv
testbench/decode_chk.sv
testbench/decode_scoreboard.sv
testbench/tb_decode_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -j 0 --top-module tb_decode_top -f project.f -o tb_decode_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the runtime error limit so assertion failures reach the summary
./obj_dir/tb_decode_top +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
